// ==== cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

    localparam int opc_w  = 8;                  // Opcode width
    localparam int step_w = 3;                  // Micro-step counter width

    // The ROM matches x bits as don't care and the earlier table entry
    // wins where two patterns overlap
    typedef enum logic [opc_w-1:0] {
        NOP      = 8'b0000_0000,
        INCDEC_R = 8'b00xx_x10x,
        LD_R_N   = 8'b00xx_x110,
        JR_E     = 8'b0001_1000,
        JR_CC_E  = 8'b001x_x000,
        LD_HL_R  = 8'b0111_0xxx,
        LD_R_HL  = 8'b01xx_x110,
        LD_R_R   = 8'b01xx_xxxx,
        ALU_A_HL = 8'b10xx_x110,
        ALU_A_R  = 8'b10xx_xxxx,
        ALU_A_N  = 8'b11xx_x110,
        RET      = 8'b1100_1001,
        CALL_NN  = 8'b1100_1101,
        POP_RR   = 8'b11xx_0001,
        PUSH_RR  = 8'b11xx_0101
    } opcode_t;

    typedef enum logic [1:0] {COND_NZ, COND_Z, COND_NC, COND_C} cond_t;

    typedef struct packed {
        logic f_z;                              // Zero
        logic f_n;                              // Subtract
        logic f_h;                              // Half carry
        logic f_c;                              // Carry
    } flags_t;

    typedef enum logic [3:0] {
        NONE = 4'b0000,
        Z, W,                                   // Temporary pair for operands
        B, C, D, E, H, L,
        SPH, SPL,
        PCH, PCL,
        A,
        F    = 4'b1110,
        MEM  = 4'b1111                          // External memory at the address bus
    } reg8_t;

    typedef enum logic [2:0] {WZ, BC, DE, HL, AF, SP, PC} reg16_t;

    typedef enum logic [1:0] {AB_NO_MASK, AB_AND_FF00, AB_ZERO} ab_mask_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
        ALU_AND, ALU_XOR, ALU_OR, ALU_CP
    } alu_op_t;

    typedef enum logic [1:0] {ACC_A, ACC_DB, ACC_PCL} s_acc_t;

    typedef enum logic {ARG_DB, ARG_ONE} s_arg_t;

    typedef enum logic {R_WB_DB, R_WB_ALU} s_r_wb_t;

    typedef enum logic [1:0] {RR_WB_NONE, RR_WB_IDU, RR_WB_WZ} s_rr_wb_t;

    // ADJ carries the relative jump into the high byte
    typedef enum logic [1:0] {INC, DEC, ADJ} idu_mode_t;

endpackage

// ==== step_ctrl_if.sv ====
interface step_ctrl_if (
    input logic clk,
    input logic rst
);
    logic                            done;         // Last step of the instruction
    logic                            is_cond;      // Step branches on the condition
    cpu_ctrl_pkg::cond_t             cond;
    logic [cpu_ctrl_pkg::step_w-1:0] next_cond;    // Step taken when the condition fails

    modport decoder (
        input  clk,
        input  rst,
        output done,
        output is_cond,
        output cond,
        output next_cond
    );

    modport sequencer (
        input done,
        input is_cond,
        input cond,
        input next_cond
    );
endinterface

// ==== operand_decoder.sv ====
module operand_decoder (
    input  logic [cpu_ctrl_pkg::opc_w-1:0] ir,
    input  logic                           is_stk,    // Field 3 names AF instead of SP
    output cpu_ctrl_pkg::reg8_t            r8_dst,
    output cpu_ctrl_pkg::reg8_t            r8_src,
    output cpu_ctrl_pkg::reg16_t           r16,
    output cpu_ctrl_pkg::reg8_t            r16h,
    output cpu_ctrl_pkg::reg8_t            r16l
);
    function automatic cpu_ctrl_pkg::reg8_t r8_sel(input logic [2:0] field);
        cpu_ctrl_pkg::reg8_t sel;
        case (field)
            3'd0:    sel = cpu_ctrl_pkg::B;
            3'd1:    sel = cpu_ctrl_pkg::C;
            3'd2:    sel = cpu_ctrl_pkg::D;
            3'd3:    sel = cpu_ctrl_pkg::E;
            3'd4:    sel = cpu_ctrl_pkg::H;
            3'd5:    sel = cpu_ctrl_pkg::L;
            3'd6:    sel = cpu_ctrl_pkg::MEM;            // (HL)
            default: sel = cpu_ctrl_pkg::A;
        endcase
        return sel;
    endfunction

    assign r8_dst = r8_sel(ir[5:3]);
    assign r8_src = r8_sel(ir[2:0]);

    always_comb begin
        r16  = cpu_ctrl_pkg::SP;
        r16h = cpu_ctrl_pkg::SPH;
        r16l = cpu_ctrl_pkg::SPL;
        case (ir[5:4])
            2'd0: begin
                r16  = cpu_ctrl_pkg::BC;
                r16h = cpu_ctrl_pkg::B;
                r16l = cpu_ctrl_pkg::C;
            end
            2'd1: begin
                r16  = cpu_ctrl_pkg::DE;
                r16h = cpu_ctrl_pkg::D;
                r16l = cpu_ctrl_pkg::E;
            end
            2'd2: begin
                r16  = cpu_ctrl_pkg::HL;
                r16h = cpu_ctrl_pkg::H;
                r16l = cpu_ctrl_pkg::L;
            end
            default: if (is_stk) begin
                r16  = cpu_ctrl_pkg::AF;
                r16h = cpu_ctrl_pkg::A;
                r16l = cpu_ctrl_pkg::F;
            end
        endcase
    end
endmodule

// ==== microcode_rom.sv ====
module microcode_rom (
    input  logic [cpu_ctrl_pkg::opc_w-1:0]  ir,
    input  logic [cpu_ctrl_pkg::step_w-1:0] step,
    step_ctrl_if.decoder                    ctrl,
    output cpu_ctrl_pkg::reg16_t            s_ab,       // Address bus source
    output cpu_ctrl_pkg::ab_mask_t          ab_mask,
    output cpu_ctrl_pkg::reg8_t             s_db,       // Data bus source
    output cpu_ctrl_pkg::reg8_t             t_db,       // Data bus target
    output cpu_ctrl_pkg::s_r_wb_t           s_r_wb,
    output cpu_ctrl_pkg::alu_op_t           alu_op,
    output cpu_ctrl_pkg::s_acc_t            s_acc,
    output cpu_ctrl_pkg::s_arg_t            s_arg,
    output cpu_ctrl_pkg::idu_mode_t         idu,
    output cpu_ctrl_pkg::s_rr_wb_t          s_rr_wb,
    output cpu_ctrl_pkg::reg16_t            t_rr_wb,
    output logic                            wr_pc       // PC takes the IDU result
);
    cpu_ctrl_pkg::reg8_t  r8_dst;
    cpu_ctrl_pkg::reg8_t  r8_src;
    cpu_ctrl_pkg::reg16_t r16;
    cpu_ctrl_pkg::reg8_t  r16h;
    cpu_ctrl_pkg::reg8_t  r16l;
    logic                 is_stk;
    logic                 imm;          // Z <- [PC] and PC advances
    logic                 sp_adj;       // SP addresses memory and takes the IDU result
    logic                 in_table;

    // PUSH and POP are the only pair users and both sit in block 3
    assign is_stk = (ir[7:6] == 2'b11);
    assign ctrl.cond = cpu_ctrl_pkg::cond_t'(ir[4:3]);

    operand_decoder u_operands (.*);

    always_comb begin
        ctrl.done      = 1'b0;
        ctrl.is_cond   = 1'b0;
        ctrl.next_cond = '0;
        imm            = 1'b0;
        sp_adj         = 1'b0;
        in_table       = 1'b1;
        s_ab           = cpu_ctrl_pkg::PC;
        ab_mask        = cpu_ctrl_pkg::AB_NO_MASK;
        s_db           = r8_src;
        t_db           = cpu_ctrl_pkg::NONE;            // No register or memory write
        s_r_wb         = cpu_ctrl_pkg::R_WB_DB;
        alu_op         = cpu_ctrl_pkg::alu_op_t'(ir[5:3]);
        s_acc          = cpu_ctrl_pkg::ACC_A;
        s_arg          = cpu_ctrl_pkg::ARG_DB;
        idu            = cpu_ctrl_pkg::INC;
        s_rr_wb        = cpu_ctrl_pkg::RR_WB_NONE;
        t_rr_wb        = cpu_ctrl_pkg::WZ;
        wr_pc          = 1'b0;
        casex ({ir, step})
            {cpu_ctrl_pkg::NOP, 3'd0}, {cpu_ctrl_pkg::LD_HL_R, 3'd1},
            {cpu_ctrl_pkg::JR_CC_E, 3'd3}, {cpu_ctrl_pkg::CALL_NN, 3'd5},
            {cpu_ctrl_pkg::RET, 3'd3}, {cpu_ctrl_pkg::PUSH_RR, 3'd3}: ctrl.done = 1'b1;
            {cpu_ctrl_pkg::LD_R_N, 3'd0}, {cpu_ctrl_pkg::ALU_A_N, 3'd0},
            {cpu_ctrl_pkg::JR_E, 3'd0}, {cpu_ctrl_pkg::CALL_NN, 3'd0}: imm = 1'b1;
            {cpu_ctrl_pkg::LD_HL_R, 3'd0}: begin
                s_ab = cpu_ctrl_pkg::HL;
                t_db = cpu_ctrl_pkg::MEM;
            end
            {cpu_ctrl_pkg::LD_R_HL, 3'd0}, {cpu_ctrl_pkg::ALU_A_HL, 3'd0}: begin
                s_ab = cpu_ctrl_pkg::HL;
                s_db = cpu_ctrl_pkg::MEM;
                t_db = cpu_ctrl_pkg::Z;
            end
            {cpu_ctrl_pkg::LD_R_HL, 3'd1}, {cpu_ctrl_pkg::LD_R_N, 3'd1}: begin
                ctrl.done = 1'b1;
                s_db      = cpu_ctrl_pkg::Z;
                t_db      = r8_dst;
            end
            {cpu_ctrl_pkg::LD_R_R, 3'd0}: begin
                ctrl.done = 1'b1;
                t_db      = r8_dst;
            end
            {cpu_ctrl_pkg::ALU_A_HL, 3'd1}, {cpu_ctrl_pkg::ALU_A_N, 3'd1}: begin
                ctrl.done = 1'b1;
                s_db      = cpu_ctrl_pkg::Z;
                t_db      = cpu_ctrl_pkg::A;
                s_r_wb    = cpu_ctrl_pkg::R_WB_ALU;
            end
            {cpu_ctrl_pkg::ALU_A_R, 3'd0}: begin
                ctrl.done = 1'b1;
                t_db      = cpu_ctrl_pkg::A;
                s_r_wb    = cpu_ctrl_pkg::R_WB_ALU;
            end
            {cpu_ctrl_pkg::INCDEC_R, 3'd0}: begin
                ctrl.done = 1'b1;
                s_db      = r8_dst;
                t_db      = r8_dst;
                s_r_wb    = cpu_ctrl_pkg::R_WB_ALU;
                s_acc     = cpu_ctrl_pkg::ACC_DB;
                s_arg     = cpu_ctrl_pkg::ARG_ONE;
                alu_op    = ir[0] ? cpu_ctrl_pkg::ALU_SUB : cpu_ctrl_pkg::ALU_ADD;
            end
            {cpu_ctrl_pkg::JR_CC_E, 3'd0}: begin
                imm            = 1'b1;
                ctrl.is_cond   = 1'b1;
                ctrl.next_cond = 3'd3;                  // Not taken skips to the PC step
            end
            {cpu_ctrl_pkg::JR_E, 3'd1}, {cpu_ctrl_pkg::JR_CC_E, 3'd1}: begin
                ab_mask = cpu_ctrl_pkg::AB_AND_FF00;    // High byte of PC into W
                idu     = cpu_ctrl_pkg::ADJ;
                s_db    = cpu_ctrl_pkg::Z;
                t_db    = cpu_ctrl_pkg::Z;              // Z <- PCL + e
                s_r_wb  = cpu_ctrl_pkg::R_WB_ALU;
                alu_op  = cpu_ctrl_pkg::ALU_ADD;
                s_acc   = cpu_ctrl_pkg::ACC_PCL;
                s_rr_wb = cpu_ctrl_pkg::RR_WB_IDU;
                t_rr_wb = cpu_ctrl_pkg::WZ;
            end
            {cpu_ctrl_pkg::JR_E, 3'd2}, {cpu_ctrl_pkg::JR_CC_E, 3'd2}: begin
                ctrl.done = 1'b1;
                s_ab      = cpu_ctrl_pkg::WZ;
            end
            {cpu_ctrl_pkg::CALL_NN, 3'd1}: begin
                s_db  = cpu_ctrl_pkg::MEM;
                t_db  = cpu_ctrl_pkg::W;
                wr_pc = 1'b1;
            end
            {cpu_ctrl_pkg::CALL_NN, 3'd2}, {cpu_ctrl_pkg::PUSH_RR, 3'd0}: begin
                sp_adj = 1'b1;
                idu    = cpu_ctrl_pkg::DEC;
            end
            {cpu_ctrl_pkg::CALL_NN, 3'd3}: begin
                sp_adj = 1'b1;
                idu    = cpu_ctrl_pkg::DEC;
                s_db   = cpu_ctrl_pkg::PCH;
                t_db   = cpu_ctrl_pkg::MEM;
            end
            {cpu_ctrl_pkg::CALL_NN, 3'd4}: begin
                s_ab    = cpu_ctrl_pkg::SP;
                s_db    = cpu_ctrl_pkg::PCL;
                t_db    = cpu_ctrl_pkg::MEM;
                s_rr_wb = cpu_ctrl_pkg::RR_WB_WZ;       // Jump target into PC
                t_rr_wb = cpu_ctrl_pkg::PC;
            end
            {cpu_ctrl_pkg::RET, 3'd0}, {cpu_ctrl_pkg::POP_RR, 3'd0}: begin
                sp_adj = 1'b1;
                s_db   = cpu_ctrl_pkg::MEM;
                t_db   = cpu_ctrl_pkg::Z;
            end
            {cpu_ctrl_pkg::RET, 3'd1}, {cpu_ctrl_pkg::POP_RR, 3'd1}: begin
                sp_adj = 1'b1;
                s_db   = cpu_ctrl_pkg::MEM;
                t_db   = cpu_ctrl_pkg::W;
            end
            {cpu_ctrl_pkg::RET, 3'd2}: begin
                ab_mask = cpu_ctrl_pkg::AB_ZERO;
                s_rr_wb = cpu_ctrl_pkg::RR_WB_WZ;
                t_rr_wb = cpu_ctrl_pkg::PC;
            end
            {cpu_ctrl_pkg::PUSH_RR, 3'd1}: begin
                sp_adj = 1'b1;
                idu    = cpu_ctrl_pkg::DEC;
                s_db   = r16h;
                t_db   = cpu_ctrl_pkg::MEM;
            end
            {cpu_ctrl_pkg::PUSH_RR, 3'd2}: begin
                s_ab = cpu_ctrl_pkg::SP;
                s_db = r16l;
                t_db = cpu_ctrl_pkg::MEM;
            end
            {cpu_ctrl_pkg::POP_RR, 3'd2}: begin
                ctrl.done = 1'b1;
                s_rr_wb   = cpu_ctrl_pkg::RR_WB_WZ;
                t_rr_wb   = r16;
            end
            default: in_table = 1'b0;
        endcase
        if (imm) begin
            s_db  = cpu_ctrl_pkg::MEM;
            t_db  = cpu_ctrl_pkg::Z;
            wr_pc = 1'b1;
        end
        if (sp_adj) begin
            s_ab    = cpu_ctrl_pkg::SP;
            s_rr_wb = cpu_ctrl_pkg::RR_WB_IDU;
            t_rr_wb = cpu_ctrl_pkg::SP;
        end
        // Every last step hands PC on to the next fetch
        if (ctrl.done)
            wr_pc = 1'b1;
    end

    a_table_hit: assert property (@(posedge ctrl.clk) disable iff (!ctrl.rst) in_table)
        else $error("no microcode for opcode %h step %0d", ir, step);
endmodule

// ==== step_sequencer.sv ====
module step_sequencer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [cpu_ctrl_pkg::opc_w-1:0]  d_in,      // Next opcode on the data bus
    input  cpu_ctrl_pkg::flags_t            flags,
    step_ctrl_if.sequencer                  ctrl,
    output logic [cpu_ctrl_pkg::opc_w-1:0]  ir,
    output logic [cpu_ctrl_pkg::step_w-1:0] step
);
    logic matched;

    // Only Z and C take part in branch conditions
    always_comb begin
        case (ctrl.cond)
            cpu_ctrl_pkg::COND_NZ: matched = !flags.f_z;
            cpu_ctrl_pkg::COND_Z:  matched = flags.f_z;
            cpu_ctrl_pkg::COND_NC: matched = !flags.f_c;
            default:               matched = flags.f_c;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            ir   <= cpu_ctrl_pkg::NOP;      // First decode is a NOP fetch
            step <= '0;
        end else if (ctrl.done) begin
            ir   <= d_in;
            step <= '0;
        end else if (ctrl.is_cond && !matched) begin
            step <= ctrl.next_cond;
        end else begin
            step <= step + 1'b1;
        end
    end

    // CALL is the longest sequence at six steps
    a_step_range: assert property (@(posedge clk) disable iff (!rst) step <= 3'd5)
        else $error("step counter out of range: %0d", step);

    // Step 0 comes exactly after a last step or after reset
    a_done_restart: assert property (@(posedge clk) disable iff (!rst)
        (step == '0) == $past(ctrl.done || !rst))
        else $error("step restart out of line with done, ir %h step %0d", ir, step);
endmodule

// ==== cpu_control.sv ====
module cpu_control (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [cpu_ctrl_pkg::opc_w-1:0]  d_in,      // Opcode byte from the data bus
    input  cpu_ctrl_pkg::flags_t            flags,
    output logic [cpu_ctrl_pkg::opc_w-1:0]  ir,
    output logic [cpu_ctrl_pkg::step_w-1:0] step,
    output logic                            done,
    output cpu_ctrl_pkg::reg16_t            s_ab,
    output cpu_ctrl_pkg::ab_mask_t          ab_mask,
    output cpu_ctrl_pkg::reg8_t             s_db,
    output cpu_ctrl_pkg::reg8_t             t_db,
    output cpu_ctrl_pkg::s_r_wb_t           s_r_wb,
    output cpu_ctrl_pkg::alu_op_t           alu_op,
    output cpu_ctrl_pkg::s_acc_t            s_acc,
    output cpu_ctrl_pkg::s_arg_t            s_arg,
    output cpu_ctrl_pkg::idu_mode_t         idu,
    output cpu_ctrl_pkg::s_rr_wb_t          s_rr_wb,
    output cpu_ctrl_pkg::reg16_t            t_rr_wb,
    output logic                            wr_pc
);
    step_ctrl_if ctrl (.clk(clk), .rst(rst));

    step_sequencer u_seq (
        .clk   (clk),
        .rst   (rst),
        .d_in  (d_in),
        .flags (flags),
        .ctrl  (ctrl),
        .ir    (ir),
        .step  (step)
    );

    microcode_rom u_rom (
        .ir      (ir),
        .step    (step),
        .ctrl    (ctrl),
        .s_ab    (s_ab),
        .ab_mask (ab_mask),
        .s_db    (s_db),
        .t_db    (t_db),
        .s_r_wb  (s_r_wb),
        .alu_op  (alu_op),
        .s_acc   (s_acc),
        .s_arg   (s_arg),
        .idu     (idu),
        .s_rr_wb (s_rr_wb),
        .t_rr_wb (t_rr_wb),
        .wr_pc   (wr_pc)
    );

    assign done = ctrl.done;    // Fetch strobe for the core
endmodule

// ==== tb_ucode_model.svh ====
`ifndef TB_UCODE_MODEL_SVH
`define TB_UCODE_MODEL_SVH

typedef enum int {
    OP_NOP, OP_LD_RR, OP_LD_RN, OP_LD_RHL, OP_LD_HLR, OP_ALU_R, OP_ALU_HL, OP_ALU_N,
    OP_INCDEC, OP_JR, OP_JR_CC, OP_CALL, OP_RET, OP_PUSH, OP_POP, OP_DROPPED
} op_kind_t;

// Register field order B, C, D, E, H, L, (HL), A
cpu_ctrl_pkg::reg8_t r8_map [8] = '{
    cpu_ctrl_pkg::B, cpu_ctrl_pkg::C, cpu_ctrl_pkg::D, cpu_ctrl_pkg::E,
    cpu_ctrl_pkg::H, cpu_ctrl_pkg::L, cpu_ctrl_pkg::MEM, cpu_ctrl_pkg::A
};
// Stack pairs with AF in field 3
cpu_ctrl_pkg::reg8_t pair_hi [4] = '{
    cpu_ctrl_pkg::B, cpu_ctrl_pkg::D, cpu_ctrl_pkg::H, cpu_ctrl_pkg::A
};
cpu_ctrl_pkg::reg8_t pair_lo [4] = '{
    cpu_ctrl_pkg::C, cpu_ctrl_pkg::E, cpu_ctrl_pkg::L, cpu_ctrl_pkg::F
};
cpu_ctrl_pkg::reg16_t pair_rr [4] = '{
    cpu_ctrl_pkg::BC, cpu_ctrl_pkg::DE, cpu_ctrl_pkg::HL, cpu_ctrl_pkg::AF
};

function automatic op_kind_t classify(input logic [7:0] op);
    op_kind_t k;
    k = OP_DROPPED;
    if (op == 8'h00)
        k = OP_NOP;
    else if (op == 8'h18)
        k = OP_JR;
    else if (op == 8'hc9)
        k = OP_RET;
    else if (op == 8'hcd)
        k = OP_CALL;
    else if (op[7:6] == 2'b00) begin
        if (op[2:0] == 3'b000 && op[5])
            k = OP_JR_CC;
        else if (op[2:1] == 2'b10 && op[5:3] != 3'd6)        // INC/DEC (HL) is not kept
            k = OP_INCDEC;
        else if (op[2:0] == 3'b110 && op[5:3] != 3'd6)
            k = OP_LD_RN;
    end else if (op[7:6] == 2'b01) begin
        if (op[5:3] == 3'd6 && op[2:0] != 3'd6)
            k = OP_LD_HLR;
        else if (op[2:0] == 3'd6 && op[5:3] != 3'd6)
            k = OP_LD_RHL;
        else if (op[5:3] != 3'd6)
            k = OP_LD_RR;
    end else if (op[7:6] == 2'b10)
        k = (op[2:0] == 3'd6) ? OP_ALU_HL : OP_ALU_R;
    else if (op[2:0] == 3'd6)
        k = OP_ALU_N;
    else if (op[3:0] == 4'h1)
        k = OP_POP;
    else if (op[3:0] == 4'h5)
        k = OP_PUSH;
    return k;
endfunction

function automatic int inst_len(input op_kind_t k, input logic taken);
    case (k)
        OP_NOP, OP_LD_RR, OP_ALU_R, OP_INCDEC: return 1;
        OP_JR, OP_POP:                         return 3;
        OP_JR_CC:                              return taken ? 3 : 2;
        OP_RET, OP_PUSH:                       return 4;
        OP_CALL:                               return 6;
        default:                               return 2;
    endcase
endfunction

function automatic logic cond_holds(input logic [1:0] cc, input cpu_ctrl_pkg::flags_t f);
    case (cc)
        2'd0:    return !f.f_z;
        2'd1:    return f.f_z;
        2'd2:    return !f.f_c;
        default: return f.f_c;
    endcase
endfunction

task automatic check_step_fields(input op_kind_t k, input logic [7:0] op, input int pos,
                                 input logic jumps, input logic last);
    case (k)
        OP_LD_RR: begin
            check_value("s_db", 8'(s_db), 8'(r8_map[op[2:0]]));
            check_value("t_db", 8'(t_db), 8'(r8_map[op[5:3]]));
        end
        OP_LD_HLR: if (pos == 0) begin
            check_value("s_ab", 8'(s_ab), 8'(cpu_ctrl_pkg::HL));
            check_value("t_db", 8'(t_db), 8'(cpu_ctrl_pkg::MEM));
            check_value("s_db", 8'(s_db), 8'(r8_map[op[2:0]]));
        end
        OP_LD_RHL: if (pos == 0) begin
            check_value("s_db", 8'(s_db), 8'(cpu_ctrl_pkg::MEM));
            check_value("t_db", 8'(t_db), 8'(cpu_ctrl_pkg::Z));
        end else begin
            check_value("s_db", 8'(s_db), 8'(cpu_ctrl_pkg::Z));
            check_value("t_db", 8'(t_db), 8'(r8_map[op[5:3]]));
        end
        OP_ALU_R, OP_ALU_HL, OP_ALU_N: if (last) begin
            check_value("alu_op", 8'(alu_op), 8'(op[5:3]));
            check_value("t_db", 8'(t_db), 8'(cpu_ctrl_pkg::A));
            check_value("s_r_wb", 8'(s_r_wb), 8'(cpu_ctrl_pkg::R_WB_ALU));
        end
        OP_INCDEC: begin
            check_value("alu_op", 8'(alu_op),
                        op[0] ? 8'(cpu_ctrl_pkg::ALU_SUB) : 8'(cpu_ctrl_pkg::ALU_ADD));
            check_value("s_arg", 8'(s_arg), 8'(cpu_ctrl_pkg::ARG_ONE));
            check_value("s_acc", 8'(s_acc), 8'(cpu_ctrl_pkg::ACC_DB));
        end
        OP_PUSH: if (pos == 0) begin
            check_value("idu", 8'(idu), 8'(cpu_ctrl_pkg::DEC));
            check_value("t_rr_wb", 8'(t_rr_wb), 8'(cpu_ctrl_pkg::SP));
        end else if (pos < 3) begin
            check_value("s_db", 8'(s_db), 8'(pos == 1 ? pair_hi[op[5:4]] : pair_lo[op[5:4]]));
            check_value("t_db", 8'(t_db), 8'(cpu_ctrl_pkg::MEM));
        end
        OP_POP: if (last) begin
            check_value("s_rr_wb", 8'(s_rr_wb), 8'(cpu_ctrl_pkg::RR_WB_WZ));
            check_value("t_rr_wb", 8'(t_rr_wb), 8'(pair_rr[op[5:4]]));
        end
        OP_CALL: if (pos == 4) begin
            check_value("s_db", 8'(s_db), 8'(cpu_ctrl_pkg::PCL));
            check_value("t_db", 8'(t_db), 8'(cpu_ctrl_pkg::MEM));
            check_value("s_rr_wb", 8'(s_rr_wb), 8'(cpu_ctrl_pkg::RR_WB_WZ));
            check_value("t_rr_wb", 8'(t_rr_wb), 8'(cpu_ctrl_pkg::PC));
        end
        OP_JR, OP_JR_CC: if (jumps && pos == 1) begin
            check_value("ab_mask", 8'(ab_mask), 8'(cpu_ctrl_pkg::AB_AND_FF00));
            check_value("idu", 8'(idu), 8'(cpu_ctrl_pkg::ADJ));
            check_value("s_acc", 8'(s_acc), 8'(cpu_ctrl_pkg::ACC_PCL));
            check_value("t_rr_wb", 8'(t_rr_wb), 8'(cpu_ctrl_pkg::WZ));
        end else if (jumps && last) begin
            check_value("s_ab", 8'(s_ab), 8'(cpu_ctrl_pkg::WZ));
            check_value("wr_pc", 8'(wr_pc), 8'h01);
        end
        default: ;
    endcase
endtask

`endif

// ==== tb_cpu_control.sv ====
module tb_cpu_control;
    localparam int num_instr    = 2000;
    localparam int reset_cycles = 8;
    localparam int max_cycles   = 6 * num_instr + reset_cycles;    // CALL is the longest

    logic                    clk;
    logic                    rst;
    logic [7:0]              d_in;
    cpu_ctrl_pkg::flags_t    flags;
    logic [7:0]              ir;
    logic [2:0]              step;
    logic                    done;
    cpu_ctrl_pkg::reg16_t    s_ab;
    cpu_ctrl_pkg::ab_mask_t  ab_mask;
    cpu_ctrl_pkg::reg8_t     s_db;
    cpu_ctrl_pkg::reg8_t     t_db;
    cpu_ctrl_pkg::s_r_wb_t   s_r_wb;
    cpu_ctrl_pkg::alu_op_t   alu_op;
    cpu_ctrl_pkg::s_acc_t    s_acc;
    cpu_ctrl_pkg::s_arg_t    s_arg;
    cpu_ctrl_pkg::idu_mode_t idu;
    cpu_ctrl_pkg::s_rr_wb_t  s_rr_wb;
    cpu_ctrl_pkg::reg16_t    t_rr_wb;
    logic                    wr_pc;

    integer     seed;
    int         errors;
    int         cycles;
    int         instr_count;
    logic [7:0] kept_ops [$];
    logic [7:0] exp_ir;
    logic [2:0] exp_step;
    int         pos;                // Cycle within the current instruction
    logic       taken;              // JR cc outcome fixed at step 0
    logic       after_reset;

    cpu_control uut (.*);

    task automatic check_value(input string name, input logic [7:0] actual,
                               input logic [7:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: got %h expected %h (ir %h step %0d at %0t)",
                     name, actual, expected, exp_ir, exp_step, $time);
        end
    endtask

    `include "tb_ucode_model.svh"

    initial clk = 1'b0;
    always #5 clk = ~clk;

    initial begin
        seed        = 1696;
        errors      = 0;
        instr_count = 0;
        exp_ir      = 8'h00;        // NOP after reset
        exp_step    = 3'd0;
        pos         = 0;
        taken       = 1'b0;
        after_reset = 1'b1;
        rst         = 1'b0;
        d_in        = 8'h00;
        flags       = '0;
        for (int op = 0; op < 256; op++) begin
            if (classify(8'(op)) != OP_DROPPED)
                kept_ops.push_back(8'(op));
        end
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b1;
        wait (instr_count >= num_instr);
        $display("Checked %0d instructions in %0d cycles with %0d errors",
                 instr_count, cycles, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, only %0d instructions done, %0d errors",
                 cycles, instr_count, errors);
        $display("TEST FAIL");
        $finish;
    end

    always @(posedge clk) begin
        int pick;
        int rnd;
        rnd   = $random(seed);
        pick  = int'(rnd[15:0]) % kept_ops.size();
        d_in  <= kept_ops[pick];
        rnd   = $random(seed);
        flags <= cpu_ctrl_pkg::flags_t'(rnd[3:0]);
    end

    // Outputs settle before the falling edge and the inputs seen here are latched next
    always @(negedge clk) begin
        op_kind_t k;
        int       len;
        if (rst) begin
            k = classify(exp_ir);
            if (pos == 0 && k == OP_JR_CC)
                taken = cond_holds(exp_ir[4:3], flags);
            len = inst_len(k, taken);
            if (after_reset) begin
                check_value("t_db", 8'(t_db), 8'(cpu_ctrl_pkg::NONE));
                check_value("s_rr_wb", 8'(s_rr_wb), 8'(cpu_ctrl_pkg::RR_WB_NONE));
                check_value("wr_pc", 8'(wr_pc), 8'h01);
                after_reset = 1'b0;
            end
            check_value("ir", ir, exp_ir);
            check_value("step", 8'(step), 8'(exp_step));
            check_value("done", 8'(done), 8'(pos == len - 1));
            check_step_fields(k, exp_ir, pos, taken || k == OP_JR, pos == len - 1);
            if (pos == len - 1) begin
                exp_ir   = d_in;
                exp_step = 3'd0;
                pos      = 0;
                instr_count++;
            end else begin
                exp_step = (k == OP_JR_CC && pos == 0 && !taken) ? 3'd3 : exp_step + 3'd1;
                pos++;
            end
        end
    end
endmodule

// ==== flist.f ====
+incdir+.
cpu_ctrl_pkg.sv
step_ctrl_if.sv
operand_decoder.sv
microcode_rom.sv
step_sequencer.sv
cpu_control.sv
tb_cpu_control.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu_control
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
